//--- Makefile
VERILATOR  = verilator
TOP        = tb_disp
FLIST      = flist.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "FAIL: no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+include
src/disp_pkg.sv
src/disp_cfg_regs.sv
src/disp_pattern_gen.sv
src/disp_driver.sv
src/disp_top.sv
test/disp_sva.sv
test/tb_disp.sv

//--- include/disp_defaults.svh
/*
 * Default panel timing for 640x480 at 60 Hz with a 25 MHz pixel clock.
 * One line is 800 clocks and one frame is 525 lines, borders included.
 */
`ifndef DISP_DEFAULTS_SVH
`define DISP_DEFAULTS_SVH

`define DISP_H_SYNC         12'd96
`define DISP_H_BACK_PORCH   12'd40
`define DISP_H_LEAD_BORDER  12'd8
`define DISP_H_ACTIVE       12'd640
`define DISP_H_TRAIL_BORDER 12'd8
`define DISP_H_FRONT_PORCH  12'd8

`define DISP_V_SYNC         12'd2
`define DISP_V_BACK_PORCH   12'd25
`define DISP_V_LEAD_BORDER  12'd8
`define DISP_V_ACTIVE       12'd480
`define DISP_V_TRAIL_BORDER 12'd8
`define DISP_V_FRONT_PORCH  12'd2

`endif

//--- src/disp_cfg_regs.sv
/*
 * Configuration registers for the test-pattern generator.
 * Writes land in pending registers, and the shadow copy seen by the
 * generator is only refreshed at frame start so a frame is never torn.
 */
module disp_cfg_regs (
	input  logic                 ClkDisp,
	input  logic                 Rst_n,
	input  logic                 reg_wr,
	input  logic [1:0]           reg_addr,
	input  logic [15:0]          reg_wdata,
	output logic [15:0]          reg_rdata,
	input  logic                 frame_start,
	output disp_pkg::disp_cfg_t  cfg
);

	disp_pkg::disp_cfg_t pend; // values as last written by software.

	// Pending registers, written straight from the strobe.
	always_ff @(posedge ClkDisp or negedge Rst_n) begin
		if (!Rst_n) begin
			pend.enable        <= 1'b0;
			pend.pattern       <= disp_pkg::PAT_SOLID;
			pend.checker_shift <= 2'd0;
			pend.fg            <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				disp_pkg::REG_CTRL: begin
					pend.enable        <= reg_wdata[0];
					pend.pattern       <= disp_pkg::pattern_e'(reg_wdata[2:1]);
					pend.checker_shift <= reg_wdata[5:4];
				end
				disp_pkg::REG_FG: begin
					pend.fg <= disp_pkg::rgb_t'(reg_wdata);
				end
				default: begin
					pend <= pend; // unmapped addresses are ignored.
				end
			endcase
		end
	end

	// readback shows the pending value, not what the panel is showing.
	always_comb begin
		reg_rdata = '0;
		case (reg_addr)
			disp_pkg::REG_CTRL: begin
				reg_rdata[0]   = pend.enable;
				reg_rdata[2:1] = pend.pattern;
				reg_rdata[5:4] = pend.checker_shift;
			end
			disp_pkg::REG_FG: begin
				reg_rdata = pend.fg;
			end
			default: begin
				reg_rdata = '0;
			end
		endcase
	end

	// Shadow copy used for scan-out.
	always_ff @(posedge ClkDisp or negedge Rst_n) begin
		if (!Rst_n) begin
			cfg.enable        <= 1'b0;
			cfg.pattern       <= disp_pkg::PAT_SOLID;
			cfg.checker_shift <= 2'd0;
			cfg.fg            <= '0;
		end else if (frame_start) begin
			cfg <= pend; // whole word moves at once.
		end
	end

endmodule

//--- src/disp_driver.sv
/*
 * Display timing generator for a parallel RGB panel.
 * Runs the line and frame counters, requests pixels across the active
 * window, and registers sync, data enable and colour in one aligned stage.
 */
module disp_driver #(
	parameter disp_pkg::disp_timing_t H_TIMING = disp_pkg::DEF_H_TIMING,
	parameter disp_pkg::disp_timing_t V_TIMING = disp_pkg::DEF_V_TIMING
) (
	input  logic                 ClkDisp,
	input  logic                 Rst_n,
	input  disp_pkg::rgb_t       pixel,
	output logic                 data_req,
	output logic [11:0]          h_addr,
	output logic [11:0]          v_addr,
	output logic                 frame_start,
	output disp_pkg::disp_out_t  disp
);

	// Window limits; the active window is [BEGIN, END) on each axis.
	localparam logic [11:0] H_BEGIN = H_TIMING.sync + H_TIMING.back_porch
		+ H_TIMING.lead_border;
	localparam logic [11:0] H_END   = H_BEGIN + H_TIMING.active;
	localparam logic [11:0] H_TOTAL = H_END + H_TIMING.trail_border + H_TIMING.front_porch;

	localparam logic [11:0] V_BEGIN = V_TIMING.sync + V_TIMING.back_porch
		+ V_TIMING.lead_border;
	localparam logic [11:0] V_END   = V_BEGIN + V_TIMING.active;
	localparam logic [11:0] V_TOTAL = V_END + V_TIMING.trail_border + V_TIMING.front_porch;

	logic [11:0] hcount;
	logic [11:0] vcount;
	logic        h_wrap;    // last clock of a line.
	logic        v_wrap;    // last line of a frame.
	logic        in_window;
	logic        hs_s1;     // sync levels held back one stage to match the request.
	logic        vs_s1;

	assign h_wrap = (hcount == H_TOTAL - 12'd1);
	assign v_wrap = (vcount == V_TOTAL - 12'd1);

	assign in_window = (hcount >= H_BEGIN) && (hcount < H_END)
		&& (vcount >= V_BEGIN) && (vcount < V_END);

	always_ff @(posedge ClkDisp or negedge Rst_n) begin
		if (!Rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			hcount <= h_wrap ? 12'd0 : hcount + 12'd1;
			if (h_wrap) begin
				vcount <= v_wrap ? 12'd0 : vcount + 12'd1; // steps once per line.
			end
		end
	end

	// high exactly while both counters sit at zero, except right after reset.
	always_ff @(posedge ClkDisp or negedge Rst_n) begin
		if (!Rst_n) begin
			frame_start <= 1'b0;
		end else begin
			frame_start <= h_wrap && v_wrap;
		end
	end

	// Stage 1: pixel request and addresses.
	always_ff @(posedge ClkDisp or negedge Rst_n) begin
		if (!Rst_n) begin
			data_req <= 1'b0;
			h_addr   <= '0;
			v_addr   <= '0;
			hs_s1    <= 1'b1;
			vs_s1    <= 1'b1;
		end else begin
			data_req <= in_window;
			h_addr   <= in_window ? hcount - H_BEGIN : 12'd0;
			v_addr   <= in_window ? vcount - V_BEGIN : 12'd0;
			hs_s1    <= (hcount >= H_TIMING.sync);
			vs_s1    <= (vcount >= V_TIMING.sync);
		end
	end

	// Stage 2: panel outputs, all one clock after the request.
	always_ff @(posedge ClkDisp or negedge Rst_n) begin
		if (!Rst_n) begin
			disp.hs  <= 1'b1;
			disp.vs  <= 1'b1;
			disp.de  <= 1'b0;
			disp.rgb <= '0;
		end else begin
			disp.hs  <= hs_s1;
			disp.vs  <= vs_s1;
			disp.de  <= data_req;
			disp.rgb <= data_req ? pixel : '0; // blanking is black.
		end
	end

endmodule

//--- src/disp_pattern_gen.sv
/*
 * Test-pattern generator.
 * Answers a pixel request with the colour of the configured pattern at the
 * requested address, in the same cycle.
 */
module disp_pattern_gen #(
	parameter int H_ACTIVE = 640
) (
	input  logic [11:0]          h_addr,
	input  logic [11:0]          v_addr,
	input  logic                 data_req,
	input  disp_pkg::disp_cfg_t  cfg,
	output disp_pkg::rgb_t       pixel
);

	logic [2:0]     bar_k;       // colour bar index, 0 at the left edge.
	disp_pkg::rgb_t pat_rgb;     // pattern colour before blanking.
	logic           checker_hit;

	// The bar edges are k*H_ACTIVE/8 for k = 1..7.
	// They are constants, so each test becomes a fixed compare.
	always_comb begin
		bar_k = 3'd0;
		for (int k = 1; k < 8; k++) begin
			if (int'(h_addr) >= (k * H_ACTIVE) / 8) begin
				bar_k = bar_k + 3'd1;
			end
		end
	end

	assign checker_hit = disp_pkg::checker_on(h_addr, v_addr, cfg.checker_shift);

	always_comb begin
		case (cfg.pattern)
			disp_pkg::PAT_SOLID: begin
				pat_rgb = cfg.fg;
			end
			disp_pkg::PAT_BARS: begin
				pat_rgb = disp_pkg::bar_rgb(bar_k);
			end
			disp_pkg::PAT_CHECKER: begin
				pat_rgb = checker_hit ? cfg.fg : '0; // black between squares.
			end
			disp_pkg::PAT_GRADIENT: begin
				pat_rgb = disp_pkg::gradient_rgb(h_addr, v_addr);
			end
			default: begin
				pat_rgb = '0;
			end
		endcase
	end

	// Outside a request, or when disabled, the generator sends black.
	assign pixel = (cfg.enable && data_req) ? pat_rgb : '0;

endmodule

//--- src/disp_pkg.sv
/*
 * Display subsystem package.
 * Pixel, timing, configuration and panel output types, the register map,
 * and the colour rules shared by the pattern generator and its checks.
 */
package disp_pkg;

`include "disp_defaults.svh"

	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb_t; // rgb565 pixel.

	// one axis of panel timing, in the order the counter walks through it.
	typedef struct packed {
		logic [11:0] sync;
		logic [11:0] back_porch;
		logic [11:0] lead_border;
		logic [11:0] active;
		logic [11:0] trail_border;
		logic [11:0] front_porch;
	} disp_timing_t;

	localparam disp_timing_t DEF_H_TIMING = '{`DISP_H_SYNC, `DISP_H_BACK_PORCH,
		`DISP_H_LEAD_BORDER, `DISP_H_ACTIVE, `DISP_H_TRAIL_BORDER, `DISP_H_FRONT_PORCH};
	localparam disp_timing_t DEF_V_TIMING = '{`DISP_V_SYNC, `DISP_V_BACK_PORCH,
		`DISP_V_LEAD_BORDER, `DISP_V_ACTIVE, `DISP_V_TRAIL_BORDER, `DISP_V_FRONT_PORCH};

	typedef enum logic [1:0] {
		PAT_SOLID    = 2'd0,
		PAT_BARS     = 2'd1,
		PAT_CHECKER  = 2'd2,
		PAT_GRADIENT = 2'd3
	} pattern_e;

	typedef struct packed {
		logic       enable;
		pattern_e   pattern;
		logic [1:0] checker_shift; // square edge is 2^(checker_shift+1) pixels.
		rgb_t       fg;
	} disp_cfg_t;

	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_FG   = 2'd1;

	typedef struct packed {
		logic hs; // active low.
		logic vs; // active low.
		logic de;
		rgb_t rgb;
	} disp_out_t;

	// Bar k lights red, green and blue from bits 2, 1 and 0 of its index.
	function automatic rgb_t bar_rgb(input logic [2:0] k);
		rgb_t c;
		c.red   = {5{k[2]}};
		c.green = {6{k[1]}};
		c.blue  = {5{k[0]}};
		return c;
	endfunction

	function automatic rgb_t gradient_rgb(input logic [11:0] h, input logic [11:0] v);
		rgb_t c;
		c.red   = h[4:0];
		c.green = v[5:0];
		c.blue  = '0;
		return c;
	endfunction

	// true where the foreground square lies; the squares alternate on both axes.
	function automatic logic checker_on(input logic [11:0] h, input logic [11:0] v,
		input logic [1:0] shift);
		logic [11:0] diff;
		diff = h ^ v;
		return diff[{1'b0, shift} + 3'd1];
	endfunction

endpackage

//--- src/disp_top.sv
/*
 * Display subsystem top.
 * Register block, test-pattern generator and panel timing generator.
 */
module disp_top #(
	parameter disp_pkg::disp_timing_t H_TIMING = disp_pkg::DEF_H_TIMING,
	parameter disp_pkg::disp_timing_t V_TIMING = disp_pkg::DEF_V_TIMING
) (
	input  logic                 ClkDisp,
	input  logic                 Rst_n,
	input  logic                 reg_wr,
	input  logic [1:0]           reg_addr,
	input  logic [15:0]          reg_wdata,
	output logic [15:0]          reg_rdata,
	output disp_pkg::disp_out_t  disp
);

	disp_pkg::disp_cfg_t cfg;         // shadow configuration for the current frame.
	disp_pkg::rgb_t      pixel;
	logic                data_req;
	logic [11:0]         h_addr;
	logic [11:0]         v_addr;
	logic                frame_start;

	disp_cfg_regs u_regs (
		.ClkDisp     (ClkDisp),
		.Rst_n       (Rst_n),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.frame_start (frame_start),
		.cfg         (cfg)
	);

	disp_pattern_gen #(
		.H_ACTIVE (H_TIMING.active)
	) u_pattern (
		.h_addr   (h_addr),
		.v_addr   (v_addr),
		.data_req (data_req),
		.cfg      (cfg),
		.pixel    (pixel)
	);

	disp_driver #(
		.H_TIMING (H_TIMING),
		.V_TIMING (V_TIMING)
	) u_driver (
		.ClkDisp     (ClkDisp),
		.Rst_n       (Rst_n),
		.pixel       (pixel),
		.data_req    (data_req),
		.h_addr      (h_addr),
		.v_addr      (v_addr),
		.frame_start (frame_start),
		.disp        (disp)
	);

endmodule

//--- test/disp_sva.sv
/*
 * Assertions on the panel output timing of the display driver.
 */
module disp_sva (
	input logic                ClkDisp,
	input logic                Rst_n,
	input logic                frame_start,
	input disp_pkg::disp_out_t disp
);

	// colour must be black during blanking.
	a_blank_black: assert property (@(posedge ClkDisp) disable iff (!Rst_n)
		!disp.de |-> disp.rgb == '0)
		else $error("rgb is not black while de is low");

	a_de_after_hs: assert property (@(posedge ClkDisp) disable iff (!Rst_n)
		$rose(disp.de) |-> disp.hs)
		else $error("de rose during horizontal sync");

	a_one_start: assert property (@(posedge ClkDisp) disable iff (!Rst_n)
		frame_start |=> !frame_start)
		else $error("frame_start high on two cycles in a row"); // one pulse per frame.

endmodule

bind disp_driver disp_sva u_sva (
	.ClkDisp     (ClkDisp),
	.Rst_n       (Rst_n),
	.frame_start (frame_start),
	.disp        (disp)
);

//--- test/tb_disp.sv
/*
 * Testbench for the display subsystem in a small 16x8 panel mode.
 * Directed tests for reset, frame geometry, registers and all four patterns.
 */
module tb_disp;

	// 27 clocks per line and 14 lines per frame.
	localparam disp_pkg::disp_timing_t H_TB = '{12'd4, 12'd3, 12'd1, 12'd16, 12'd1, 12'd2};
	localparam disp_pkg::disp_timing_t V_TB = '{12'd2, 12'd2, 12'd0, 12'd8, 12'd0, 12'd2};
	localparam int LINE_CYCLES = 27;
	localparam int FRAME_LINES = 14;
	localparam int WAIT_LIMIT  = 2 * LINE_CYCLES * FRAME_LINES; // two whole frames.

	logic                ClkDisp;
	logic                Rst_n;
	logic                reg_wr;
	logic [1:0]          reg_addr;
	logic [15:0]         reg_wdata;
	logic [15:0]         reg_rdata;
	disp_pkg::disp_out_t disp;
	logic [31:0]         lfsr;
	int                  checks;
	int                  errors;
	logic                timed_out;

	disp_top #(.H_TIMING(H_TB), .V_TIMING(V_TB)) dut (
		.ClkDisp   (ClkDisp),
		.Rst_n     (Rst_n),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.disp      (disp)
	);

	always #50 ClkDisp = ~ClkDisp;

	// Fibonacci feedback from taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function logic [15:0] rand_bits(input int n);
		logic [15:0] w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit taken.
			w = {w[14:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic logic [15:0] ctrl_word(input disp_pkg::disp_cfg_t c);
		return {10'd0, c.checker_shift, 1'b0, c.pattern, c.enable};
	endfunction

	// Reference colour for pixel (x,y) under configuration c.
	function automatic disp_pkg::rgb_t expected_pixel(input disp_pkg::disp_cfg_t c,
		input int x, input int y);
		disp_pkg::rgb_t p;
		int k;
		int sq;
		p = '0;
		k = 0;
		sq = 2 << c.checker_shift; // square edge in pixels.
		for (int b = 1; b < 8; b++) begin
			if (x >= b * int'(H_TB.active) / 8) begin
				k++;
			end
		end
		if (c.enable) begin
			case (c.pattern)
				disp_pkg::PAT_SOLID: p = c.fg;
				disp_pkg::PAT_BARS: p = '{k[2] ? 5'h1f : 5'h0, k[1] ? 6'h3f : 6'h0,
					k[0] ? 5'h1f : 5'h0};
				disp_pkg::PAT_CHECKER: p = ((x / sq) % 2 != (y / sq) % 2) ? c.fg : '0;
				default: p = '{5'(x % 32), 6'(y % 64), 5'd0};
			endcase
		end
		return p;
	endfunction

	task automatic check_rgb(input string name, input disp_pkg::rgb_t got,
		input disp_pkg::rgb_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Returns on the falling edge where vsync has just gone low.
	task automatic wait_vs_fall();
		logic prev;
		int n;
		n = 0;
		if (timed_out) begin
			return;
		end
		do begin
			prev = disp.vs;
			@(negedge ClkDisp);
			n++;
		end while (!(prev && !disp.vs) && n < WAIT_LIMIT);
		if (!prev || disp.vs) begin
			timed_out = 1'b1;
			$display("timeout: vsync did not fall within two frame times");
		end
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data,
		input logic [15:0] readback);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge ClkDisp);
		reg_wr = 1'b0;
		check_word("reg_rdata", reg_rdata, readback);
	endtask

	// The writes land just after one frame start and show from the next frame.
	task automatic apply_cfg(input disp_pkg::disp_cfg_t c);
		wait_vs_fall();
		if (timed_out) begin
			return;
		end
		write_reg(disp_pkg::REG_CTRL, ctrl_word(c), ctrl_word(c));
		write_reg(disp_pkg::REG_FG, c.fg, c.fg);
		wait_vs_fall();
	endtask

	// Checks one frame from the vsync fall, optionally writing fg at pixel wr_at.
	task automatic scan_frame(input disp_pkg::disp_cfg_t c, input int wr_at,
		input logic [15:0] wr_fg);
		disp_pkg::disp_out_t cur;
		disp_pkg::disp_out_t prev;
		int x;
		int y;
		int pix;
		int hs_low;
		int hs_pulses;
		int vs_low;
		int n;
		logic done;
		x = 0;
		y = 0;
		pix = 0;
		hs_low = 1; // both syncs fell on the edge the scan starts from.
		hs_pulses = 0;
		vs_low = 1;
		n = 0;
		done = 1'b0;
		prev = disp;
		if (timed_out) begin
			return;
		end
		while (!done && n < WAIT_LIMIT) begin
			@(negedge ClkDisp);
			reg_wr = 1'b0;
			cur = disp;
			n++;
			if (prev.vs && !cur.vs) begin
				done = 1'b1;
			end else begin
				if (cur.de) begin
					check_rgb($sformatf("rgb at %0d,%0d", x, y), cur.rgb,
						expected_pixel(c, x, y));
					if (pix == wr_at) begin
						reg_wr    = 1'b1;
						reg_addr  = disp_pkg::REG_FG;
						reg_wdata = wr_fg;
					end
					x++;
					pix++;
				end else if (prev.de) begin
					check_word("de per line", 16'(x), 16'(H_TB.active));
					x = 0;
					y++;
				end
				if (!cur.hs) begin
					hs_low++;
				end else if (!prev.hs) begin
					check_word("hs low width", 16'(hs_low), 16'(H_TB.sync));
					hs_low = 0;
					hs_pulses++;
				end
				if (!cur.vs) begin
					vs_low++;
				end else if (!prev.vs) begin
					check_word("vs low width", 16'(vs_low),
						16'(int'(V_TB.sync) * LINE_CYCLES));
					vs_low = 0;
				end
			end
			prev = cur;
		end
		if (done) begin
			check_word("lines with de", 16'(y), 16'(V_TB.active));
			check_word("hs pulses per frame", 16'(hs_pulses), 16'(FRAME_LINES));
		end else begin
			timed_out = 1'b1;
			$display("timeout: frame did not end within two frame times");
		end
	endtask

	task automatic show_pattern(input disp_pkg::disp_cfg_t c);
		apply_cfg(c);
		scan_frame(c, -1, 16'h0);
	endtask

	task automatic test_reset();
		for (int i = 0; i < 3; i++) begin
			@(negedge ClkDisp);
			check_bit("hs", disp.hs, 1'b1);
			check_bit("vs", disp.vs, 1'b1);
			check_bit("de", disp.de, 1'b0);
			check_rgb("rgb", disp.rgb, '0);
			if (i == 1) begin
				Rst_n = 1'b1; // released after two cycles.
			end
		end
	endtask

	task automatic test_geometry();
		wait_vs_fall();
		scan_frame('0, -1, 16'h0); // still the reset setting, all black.
	endtask

	task automatic test_registers();
		disp_pkg::disp_cfg_t c;
		logic [15:0] w;
		for (int i = 0; i < 4; i++) begin
			w = rand_bits(16);
			write_reg(disp_pkg::REG_CTRL, w, w & 16'h0037);
			w = rand_bits(16);
			write_reg(disp_pkg::REG_FG, w, w);
		end
		c = '{1'b1, disp_pkg::PAT_SOLID, 2'd0, disp_pkg::rgb_t'(rand_bits(16))};
		apply_cfg(c);
		w = rand_bits(16);
		scan_frame(c, 40, w); // the old colour holds for the rest of this frame.
		c.fg = disp_pkg::rgb_t'(w);
		scan_frame(c, -1, 16'h0);
	endtask

	task automatic test_solid_disable();
		disp_pkg::disp_cfg_t c;
		c = '{1'b1, disp_pkg::PAT_SOLID, 2'd0, disp_pkg::rgb_t'(rand_bits(16))};
		show_pattern(c);
		c.enable = 1'b0;
		show_pattern(c);
	endtask

	task automatic test_bars_gradient();
		show_pattern('{1'b1, disp_pkg::PAT_BARS, 2'd0, disp_pkg::rgb_t'(rand_bits(16))});
		show_pattern('{1'b1, disp_pkg::PAT_GRADIENT, 2'd0, disp_pkg::rgb_t'(rand_bits(16))});
	endtask

	task automatic test_checker();
		for (int s = 0; s < 4; s++) begin
			show_pattern('{1'b1, disp_pkg::PAT_CHECKER, 2'(s),
				disp_pkg::rgb_t'(rand_bits(16))});
		end
	endtask

	initial begin
		ClkDisp   = 1'b0;
		Rst_n     = 1'b0;
		reg_wr    = 1'b0;
		reg_addr  = 2'd0;
		reg_wdata = 16'h0;
		lfsr      = 32'h9d6e;
		checks    = 0;
		errors    = 0;
		timed_out = 1'b0;
		test_reset();
		test_geometry();
		test_registers();
		test_solid_disable();
		test_bars_gradient();
		test_checker();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
